/* bench/rv_core_cases.txt */
# case <name> | i <addr> <inst> | d <addr> <word> | s <paddr> <pwdata> <pstrb>
# h <halt pc> | e runs the case; all values hex
case alu
i 80000000 000010b7
i 80000004 ffb00113
i 80000008 abcde1b7
i 8000000c 12318193
i 80000010 00010217
i 80000014 0020a023
i 80000018 0030a223
i 8000001c 0040a423
i 80000020 00100073
s 00001000 fffffffb f
s 00001004 abcde123 f
s 00001008 80010010 f
h 80000020
e
case store_lanes
i 80000000 000010b7
i 80000004 11223137
i 80000008 34410113
i 8000000c 00208023
i 80000010 002080a3
i 80000014 00208123
i 80000018 002081a3
i 8000001c 00209223
i 80000020 00209323
i 80000024 00100073
s 00001000 00000044 1
s 00001000 00004400 2
s 00001000 00440000 4
s 00001000 44000000 8
s 00001004 00003344 3
s 00001004 33440000 c
h 80000024
e
case loads
i 80000000 000010b7
i 80000004 0000a103
i 80000008 0020a823
i 8000000c 00008183
i 80000010 0030aa23
i 80000014 0010c203
i 80000018 0040ac23
i 8000001c 00209283
i 80000020 0050ae23
i 80000024 0000d303
i 80000028 0260a023
i 8000002c 00308383
i 80000030 0270a223
i 80000034 00100073
d 00001000 9c7e85f3
s 00001010 9c7e85f3 f
s 00001014 fffffff3 f
s 00001018 00000085 f
s 0000101c ffff9c7e f
s 00001020 000085f3 f
s 00001024 ffffff9c f
h 80000034
e
case jumps
i 80000000 000010b7
i 80000004 00c002ef
i 80000008 00100493
i 8000000c 00200493
i 80000010 0050a023
i 80000014 00000317
i 80000018 011303e7
i 8000001c 00100493
i 80000020 00200493
i 80000024 0070a223
i 80000028 0090a423
i 8000002c 00100073
s 00001000 80000008 f
s 00001004 8000001c f
s 00001008 00000000 f
h 8000002c
e

/* flist.f */
logic/rv_core_pkg.sv
logic/rv_mem_if.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_lsu.sv
logic/rv_core_top.sv
bench/tb_clock_gen.sv
bench/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_core_pkg.sv
  - logic/rv_mem_if.sv
  - logic/rv_decoder.sv
  - logic/rv_regfile.sv
  - logic/rv_lsu.sv
  - logic/rv_core_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_rv_core.sv

/* bench/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

  localparam logic [31:0] RESET_PC  = 32'h8000_0000;
  localparam logic [31:0] DATA_BASE = 32'h0000_1000;
  localparam int          RST_CYC   = 10;

  logic        clk, gen_arst_n, case_rst_n, arst_n;
  logic [31:0] inst, prdata, pc, paddr, pwdata;
  logic        pready, halted, psel, penable, pwrite;
  logic [3:0]  pstrb;

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:63];
  logic [31:0] exp_addr[$], exp_data[$];
  logic [3:0]  exp_strb[$];
  logic [31:0] lfsr = 32'h7022d90c;
  logic [31:0] halt_pc;
  string       case_name;
  int          n_inst, errors, wait_cnt;

  tb_clock_gen #(.PERIOD(10.0), .RST_CYCLES(RST_CYC)) u_clock_gen (
    .clk    (clk),
    .arst_n (gen_arst_n)
  );

  assign arst_n = gen_arst_n & case_rst_n; // second reset source per case
  assign inst   = (pc[31:8] == RESET_PC[31:8]) ? imem[pc[7:2]] : 32'h0000_0013;

  rv_core_top #(.RESET_PC(RESET_PC)) u_rv_core_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .inst    (inst),
    .prdata  (prdata),
    .pready  (pready),
    .pc      (pc),
    .halted  (halted),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb)
  );

  // fibonacci taps 32,22,2,1
  function automatic logic next_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{strb[i]}};
    end
    return m;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", case_name, what, exp, act);
  endtask

  task automatic finish_run();
    $display("closing: %0d errors", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // fresh memories for each case, fill tied to the full address
  task automatic clear_case();
    for (int k = 0; k < 64; k++) begin
      imem[k] = 32'h0000_0013;
      dmem[k] = (DATA_BASE + 4 * k) ^ 32'h5a5a_c3c3;
    end
    exp_addr.delete();
    exp_data.delete();
    exp_strb.delete();
    n_inst = 0;
  endtask

  task automatic complete_transfer();
    logic [31:0] m;
    logic [31:0] em;
    if (paddr[31:8] != DATA_BASE[31:8]) begin
      errors++;
      $display("%s: APB address %h lies outside the data memory", case_name, paddr);
    end else if (pwrite) begin
      m = lane_mask(pstrb);
      dmem[paddr[7:2]] = (dmem[paddr[7:2]] & ~m) | (pwdata & m);
      if (exp_addr.size() == 0) begin
        errors++;
        $display("%s: unexpected store to %h", case_name, paddr);
      end else begin
        em = lane_mask(exp_strb[0]); // only the lanes the store should touch
        if (paddr !== exp_addr[0]) report_mismatch("store paddr", exp_addr[0], paddr);
        if (pstrb !== exp_strb[0]) report_mismatch("store pstrb", exp_strb[0], pstrb);
        if ((pwdata & em) !== (exp_data[0] & em)) begin
          report_mismatch("store pwdata", exp_data[0] & em, pwdata & em);
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_strb.pop_front());
      end
    end
  endtask

  task automatic run_case();
    int          cyc, halt_cnt, limit;
    logic        prev_psel, prev_stall;
    logic [31:0] prev_pc;
    limit = n_inst * 6 + RST_CYC;
    @(posedge clk);
    #1 case_rst_n = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    #1 case_rst_n = 1'b1;
    @(negedge clk);
    if (pc !== RESET_PC) report_mismatch("reset pc", RESET_PC, pc);
    if ((halted !== 1'b0) || (psel !== 1'b0) || (penable !== 1'b0)) begin
      errors++;
      $display("%s: halted, psel or penable not low after reset", case_name);
    end
    cyc        = RST_CYC;
    halt_cnt   = 0;
    prev_psel  = 1'b0;
    prev_stall = 1'b0;
    prev_pc    = pc;
    while (halt_cnt < 4) begin
      @(posedge clk);
      #1;
      if (psel && !penable) begin
        wait_cnt = {next_bit(), next_bit()}; // 0 to 3 wait states
      end
      if (psel && penable) begin
        pready = (wait_cnt == 0);
        if (wait_cnt > 0) wait_cnt--;
        prdata = (paddr[31:8] == DATA_BASE[31:8]) ? dmem[paddr[7:2]] : 32'hdead_beef;
      end else begin
        pready = 1'b0;
        prdata = '0;
      end
      @(negedge clk);
      cyc++;
      if (penable && !prev_psel) begin
        errors++;
        $display("%s: access phase without a setup phase", case_name);
      end
      if (prev_stall && (pc !== prev_pc)) report_mismatch("pc during wait", prev_pc, pc);
      if (psel && penable && pready) complete_transfer();
      if (halted) begin
        halt_cnt++;
        if (psel) begin
          errors++;
          $display("%s: APB transfer started after ebreak", case_name);
        end
      end
      prev_psel  = psel;
      prev_stall = psel && penable && !pready;
      prev_pc    = pc;
      if (cyc > limit) begin
        errors++;
        $display("%s: timeout after %0d cycles, core never halted", case_name, cyc);
        finish_run();
      end
    end
    if (pc !== halt_pc) report_mismatch("halt pc", halt_pc, pc);
    if (exp_addr.size() != 0) begin
      errors++;
      $display("%s: %0d expected stores never happened", case_name, exp_addr.size());
    end
  endtask

  initial begin
    int          fd;
    string       line, tag;
    logic [31:0] a, v, s;
    case_rst_n = 1'b1;
    pready     = 1'b0;
    prdata     = '0;
    errors     = 0;
    wait_cnt   = 0;
    clear_case();
    wait (gen_arst_n === 1'b1);
    fd = $fopen("bench/rv_core_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open bench/rv_core_cases.txt");
    end else begin
      while ($fgets(line, fd)) begin
        if ($sscanf(line, "%s", tag) != 1) continue; // blank line
        if (tag == "case") begin
          clear_case();
          void'($sscanf(line, "case %s", case_name));
        end else if (tag == "i") begin
          void'($sscanf(line, "i %h %h", a, v));
          imem[a[7:2]] = v;
          n_inst++;
        end else if (tag == "d") begin
          void'($sscanf(line, "d %h %h", a, v));
          dmem[a[7:2]] = v;
        end else if (tag == "s") begin
          void'($sscanf(line, "s %h %h %h", a, v, s));
          exp_addr.push_back(a);
          exp_data.push_back(v);
          exp_strb.push_back(s[3:0]);
        end else if (tag == "h") begin
          void'($sscanf(line, "h %h", halt_pc));
        end else if (tag == "e") begin
          run_case();
        end
      end
      $fclose(fd);
    end
    finish_run();
  end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real PERIOD     = 10.0,
  parameter int  RST_CYCLES = 10
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  // release reset a little after an edge
  initial begin
    repeat (RST_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/10ps

module rv_core_top import rv_core_pkg::*; #(
  parameter xlen_t RESET_PC = 32'h8000_0000
) (
  input  logic  clk,
  input  logic  arst_n,
  input  inst_t inst,
  input  xlen_t prdata,
  input  logic  pready,
  output xlen_t pc,
  output logic  halted,
  output logic  psel,
  output logic  penable,
  output logic  pwrite,
  output xlen_t paddr,
  output xlen_t pwdata,
  output strb_t pstrb
);

  reg_addr_t rs1, rs2, rd;
  funct3_t   funct3;
  xlen_t     imm;
  logic      use_pc, reg_we, mem_req, mem_we, jump, is_ebreak;
  wb_sel_e   wb_sel;

  xlen_t rs1_data, rs2_data;
  xlen_t sum;      // the one adder
  xlen_t pc_plus4;
  xlen_t next_pc;
  xlen_t wb_data;
  logic  retire;   // instruction finishes this cycle
  logic  rf_we;

  rv_mem_if u_mem_if ();

  rv_decoder u_rv_decoder (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .funct3    (funct3),
    .imm       (imm),
    .use_pc    (use_pc),
    .reg_we    (reg_we),
    .wb_sel    (wb_sel),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .jump      (jump),
    .is_ebreak (is_ebreak)
  );

  rv_regfile u_rv_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (rf_we),
    .waddr  (rd),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_lsu u_rv_lsu (
    .clk     (clk),
    .arst_n  (arst_n),
    .mem     (u_mem_if.lsu),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready)
  );

  assign sum      = (use_pc ? pc : rs1_data) + imm;
  assign pc_plus4 = pc + 32'd4;
  assign next_pc  = jump ? {sum[31:1], 1'b0} : pc_plus4; // jalr drops bit 0

  // memory request, held steady while pc stalls
  assign u_mem_if.req    = mem_req && !halted;
  assign u_mem_if.we     = mem_we;
  assign u_mem_if.addr   = sum;
  assign u_mem_if.wdata  = rs2_data;
  assign u_mem_if.funct3 = funct3;

  // loads and stores wait for done, ebreak never retires
  assign retire = !halted && !is_ebreak && (!mem_req || u_mem_if.done);
  assign rf_we  = reg_we && retire;

  always_comb begin
    case (wb_sel)
      wb_imm_u: wb_data = imm;
      wb_link:  wb_data = pc_plus4;
      wb_load:  wb_data = u_mem_if.rdata;
      default:  wb_data = sum;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else begin
      if (retire) begin
        pc <= next_pc;
      end
      if (is_ebreak) begin
        halted <= 1'b1; // sticky until reset
      end
    end
  end

endmodule

/* logic/rv_lsu.sv */
`timescale 1ns/10ps

module rv_lsu import rv_core_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  rv_mem_if.lsu mem,
  output logic  psel,
  output logic  penable,
  output logic  pwrite,
  output xlen_t paddr,
  output xlen_t pwdata,
  output strb_t pstrb,
  input  xlen_t prdata,
  input  logic  pready
);

  lsu_state_e state;
  lsu_state_e state_nxt;
  logic [4:0] shamt;    // lane offset in bits
  strb_t      st_strb;
  xlen_t      rd_shift; // addressed lane moved down to bit 0

  // phase sequencing
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (mem.req) begin
          state_nxt = st_setup;
        end
      end
      st_setup: state_nxt = st_access;
      st_access: begin
        if (pready) begin
          state_nxt = st_idle; // transfer completes on this edge
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  assign psel    = (state == st_setup) || (state == st_access);
  assign penable = (state == st_access);
  assign mem.done = (state == st_access) && pready;

  // payload follows the request, which the core holds steady
  assign shamt  = {mem.addr[1:0], 3'b000};
  assign paddr  = {mem.addr[31:2], 2'b00};
  assign pwrite = mem.we;
  assign pwdata = mem.wdata << shamt;

  // byte lanes touched by a store
  always_comb begin
    case (mem.funct3)
      f3_byte: st_strb = strb_t'(4'b0001 << mem.addr[1:0]);
      f3_half: st_strb = mem.addr[1] ? 4'b1100 : 4'b0011;
      f3_word: st_strb = 4'b1111;
      default: st_strb = 4'b0000;
    endcase
  end

  assign pstrb = mem.we ? st_strb : '0; // reads drive no strobe

  // load extract and extend
  assign rd_shift = prdata >> shamt;

  always_comb begin
    case (mem.funct3)
      f3_byte:   mem.rdata = {{24{rd_shift[7]}}, rd_shift[7:0]};
      f3_half:   mem.rdata = {{16{rd_shift[15]}}, rd_shift[15:0]};
      f3_byte_u: mem.rdata = {24'h00_0000, rd_shift[7:0]};
      f3_half_u: mem.rdata = {16'h0000, rd_shift[15:0]};
      default:   mem.rdata = prdata; // lw
    endcase
  end

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      we,
  input  reg_addr_t waddr,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  input  xlen_t     wdata,
  output xlen_t     rdata1,
  output xlen_t     rdata2
);

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, x0 reads as zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* logic/rv_decoder.sv */
`timescale 1ns/10ps

module rv_decoder import rv_core_pkg::*; (
  input  inst_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output funct3_t   funct3,
  output xlen_t     imm,
  output logic      use_pc,    // adder takes pc instead of rs1
  output logic      reg_we,
  output wb_sel_e   wb_sel,
  output logic      mem_req,
  output logic      mem_we,
  output logic      jump,
  output logic      is_ebreak
);

  opcode_e opcode;
  xlen_t   imm_i;
  xlen_t   imm_s;
  xlen_t   imm_u;
  xlen_t   imm_j;

  // fixed field positions
  assign opcode = opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // immediates, sign bit always inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // anything unmatched retires as a no-op
    imm       = '0;
    use_pc    = 1'b0;
    reg_we    = 1'b0;
    wb_sel    = wb_sum;
    mem_req   = 1'b0;
    mem_we    = 1'b0;
    jump      = 1'b0;
    is_ebreak = 1'b0;

    case (opcode)
      op_imm: begin
        if (funct3 == 3'b000) begin // addi only
          imm    = imm_i;
          reg_we = 1'b1;
        end
      end
      op_auipc: begin
        imm    = imm_u;
        use_pc = 1'b1;
        reg_we = 1'b1;
      end
      op_lui: begin
        imm    = imm_u;
        reg_we = 1'b1;
        wb_sel = wb_imm_u;
      end
      op_jal: begin
        imm    = imm_j;
        use_pc = 1'b1;
        reg_we = 1'b1;
        wb_sel = wb_link;
        jump   = 1'b1;
      end
      op_jalr: begin
        if (funct3 == 3'b000) begin
          imm    = imm_i;
          reg_we = 1'b1;
          wb_sel = wb_link;
          jump   = 1'b1;
        end
      end
      op_load: begin
        if (funct3 inside {f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u}) begin
          imm     = imm_i;
          reg_we  = 1'b1; // gated by done in the top
          wb_sel  = wb_load;
          mem_req = 1'b1;
        end
      end
      op_store: begin
        if (funct3 inside {f3_byte, f3_half, f3_word}) begin
          imm     = imm_s;
          mem_req = 1'b1;
          mem_we  = 1'b1;
        end
      end
      op_system: begin
        is_ebreak = (inst == ebreak_inst); // ecall etc. fall through as no-op
      end
      default: ;
    endcase
  end

endmodule

/* logic/rv_mem_if.sv */
`timescale 1ns/10ps

// request/response path from the datapath to the load/store unit
interface rv_mem_if import rv_core_pkg::*; ();

  logic    req;    // held until done
  logic    we;     // store when high
  xlen_t   addr;   // byte address from the adder
  xlen_t   wdata;  // rs2, not yet lane shifted
  funct3_t funct3; // access width and sign
  xlen_t   rdata;  // aligned, extended load result
  logic    done;   // single cycle completion

  modport core (
    output req, we, addr, wdata, funct3,
    input  rdata, done
  );

  modport lsu (
    input  req, we, addr, wdata, funct3,
    output rdata, done
  );

endinterface

/* logic/rv_core_pkg.sv */
package rv_core_pkg;

  // widths that carry a meaning
  typedef logic [31:0] xlen_t;     // data or address word
  typedef logic [31:0] inst_t;     // raw instruction word
  typedef logic [4:0]  reg_addr_t; // register index
  typedef logic [2:0]  funct3_t;   // load/store width selector
  typedef logic [3:0]  strb_t;     // apb byte strobe

  // major opcodes of the kept subset
  typedef enum logic [6:0] {
    op_imm    = 7'b001_0011,
    op_auipc  = 7'b001_0111,
    op_lui    = 7'b011_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_system = 7'b111_0011
  } opcode_e;

  // write-back source
  typedef enum logic [1:0] {
    wb_sum   = 2'd0, // adder result
    wb_imm_u = 2'd1, // lui
    wb_link  = 2'd2, // pc + 4
    wb_load  = 2'd3  // extended load data
  } wb_sel_e;

  // funct3 width codes shared by loads and stores
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  // the only system instruction kept
  localparam inst_t ebreak_inst = 32'h0010_0073;

  // apb master phases
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_setup  = 2'd1,
    st_access = 2'd2
  } lsu_state_e;

endpackage
